//--- verilog/morse_defines.svh
/* sizes and timing constants for the Morse terminal
   include wherever a pattern, slot or tick width is needed */
`ifndef MORSE_DEFINES_SVH
`define MORSE_DEFINES_SVH

// most elements in one pattern
`define MORSE_MAX_LEN 5

// character buffer depth and index width
`define MORSE_SLOTS 8
`define MORSE_SLOT_W 3

// clock cycles per dot unit, kept short for simulation
`define MORSE_DOT_TICKS 4

// cycles each display digit is held
`define MORSE_SCAN_TICKS 16

`endif

//--- verilog/morse_pkg.sv
/* character codes, pattern type and the Morse and glyph tables
   shared by the decoder, the player, the scanner and the testbench */
`include "morse_defines.svh"

package morse_pkg;

    typedef enum logic [5:0] {
        BLANK = 6'd0,
        A, B, C, D, E, F, G, H, I, J, K, L, M,
        N, O, P, Q, R, S, T, U, V, W, X, Y, Z,
        DIG_1, DIG_2, DIG_3, DIG_4, DIG_5, DIG_6, DIG_7, DIG_8, DIG_9, DIG_0
    } char_code_t;

    // first element in the top bit, dash = 1, unused bits stay zero
    typedef struct packed {
        logic [2:0]                len;
        logic [`MORSE_MAX_LEN-1:0] elems;
    } morse_pattern_t;

    // indexed by char_code_t, {len, elems}
    localparam morse_pattern_t PATTERN_TABLE [0:36] = '{
        8'b000_00000,
        8'b010_01000, 8'b100_10000, 8'b100_10100, 8'b011_10000, 8'b001_00000,
        8'b100_00100, 8'b011_11000, 8'b100_00000, 8'b010_00000, 8'b100_01110,
        8'b011_10100, 8'b100_01000, 8'b010_11000, 8'b010_10000, 8'b011_11100,
        8'b100_01100, 8'b100_11010, 8'b011_01000, 8'b011_00000, 8'b001_10000,
        8'b011_00100, 8'b100_00010, 8'b011_01100, 8'b100_10010, 8'b100_10110,
        8'b100_11000,
        8'b101_01111, 8'b101_00111, 8'b101_00011, 8'b101_00001, 8'b101_00000,
        8'b101_10000, 8'b101_11000, 8'b101_11100, 8'b101_11110, 8'b101_11111
    };

    // segments gfedcba, active high here, inverted on the way out
    localparam logic [6:0] GLYPH_TABLE [0:36] = '{
        7'h00,
        7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71, 7'h3D, 7'h76, 7'h30, 7'h1E,
        7'h75, 7'h38, 7'h37, 7'h54, 7'h5C, 7'h73, 7'h67, 7'h50, 7'h6D, 7'h78,
        7'h3E, 7'h1C, 7'h2A, 7'h49, 7'h6E, 7'h5B,
        7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07, 7'h7F, 7'h6F, 7'h3F
    };

    function automatic morse_pattern_t char_to_pattern(input char_code_t c);
        if (c > DIG_0)
            return '0;
        return PATTERN_TABLE[c];
    endfunction

    function automatic char_code_t pattern_to_char(input morse_pattern_t p);
        char_code_t c;
        c = BLANK;
        for (int i = 1; i <= 36; i++) begin
            if (PATTERN_TABLE[i] == p)
                c = char_code_t'(6'(i));
        end
        return c;
    endfunction

    // {dp, g..a}, all active low, dp always off
    function automatic logic [7:0] char_to_glyph(input char_code_t c);
        if (c > DIG_0)
            return 8'hFF;
        return {1'b1, ~GLYPH_TABLE[c]};
    endfunction

endpackage

//--- verilog/buffer_read_if.sv
/* one client's arbitrated read of the character buffer
   client raises req with slot, data is valid while grant is high */
`timescale 1ns/1ps
`include "morse_defines.svh"

interface buffer_read_if import morse_pkg::*; ();

    logic                     req;
    logic [`MORSE_SLOT_W-1:0] slot;
    logic                     grant;
    char_code_t               data;

    modport client (output req, output slot, input grant, input data);

    modport arbiter (input req, input slot, output grant, output data);

endinterface

//--- verilog/morse_decoder.sv
/* collects dot/dash elements, decodes them on commit and
   drives buffer pushes and deletes; backspace edits pattern or buffer */
`timescale 1ns/1ps
`include "morse_defines.svh"

module morse_decoder import morse_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dot,
    input  logic                      dash,
    input  logic                      commit,
    input  logic                      backspace,
    output logic [`MORSE_MAX_LEN-1:0] pattern_leds,
    output logic [`MORSE_MAX_LEN-1:0] length_leds,
    output logic                      error,
    output logic                      push,
    output logic                      delete,
    output char_code_t                push_char
);

    morse_pattern_t pat;
    char_code_t     decoded;
    logic           element;

    assign element = dot || dash;
    assign decoded = pattern_to_char(pat);

    // buffer strobes act in the commit/backspace cycle itself
    assign push      = commit && (decoded != BLANK);
    assign push_char = decoded;
    assign delete    = backspace && !commit && (pat.len == '0);

    assign pattern_leds = pat.elems;
    assign length_leds  = ~({`MORSE_MAX_LEN{1'b1}} >> pat.len); // thermometer from the top

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pat   <= '0;
            error <= 1'b0;
        end else if (commit) begin
            pat   <= '0;
            error <= (decoded == BLANK); // empty or unknown pattern
        end else if (backspace) begin
            if (pat.len != '0) begin
                pat.elems[`MORSE_MAX_LEN - pat.len] <= 1'b0; // drop last element
                pat.len <= pat.len - 3'd1;
            end
        end else if (element) begin
            error <= 1'b0;
            if (pat.len < 3'(`MORSE_MAX_LEN)) begin
                pat.elems[`MORSE_MAX_LEN - 1 - pat.len] <= dash;
                pat.len <= pat.len + 3'd1;
            end
        end
    end

    a_len_bound : assert property (@(posedge clk) disable iff (reset)
        pat.len <= 3'(`MORSE_MAX_LEN))
        else $error("pattern length over %0d", `MORSE_MAX_LEN);

endmodule

//--- verilog/char_buffer.sv
/* eight-slot character shift buffer, newest in slot 0
   push shifts up and writes slot 0, delete shifts down and blanks the top */
`timescale 1ns/1ps
`include "morse_defines.svh"

module char_buffer import morse_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     push,
    input  logic                     delete,
    input  char_code_t               push_char,
    input  logic [`MORSE_SLOT_W-1:0] read_slot,
    output char_code_t               read_data
);

    char_code_t slots [`MORSE_SLOTS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `MORSE_SLOTS; i++)
                slots[i] <= BLANK;
        end else if (push) begin
            slots[0] <= push_char;
            for (int i = 1; i < `MORSE_SLOTS; i++)
                slots[i] <= slots[i-1]; // oldest falls off the top
        end else if (delete) begin
            for (int i = 0; i < `MORSE_SLOTS - 1; i++)
                slots[i] <= slots[i+1];
            slots[`MORSE_SLOTS-1] <= BLANK;
        end
    end

    assign read_data = slots[read_slot];

    a_one_op : assert property (@(posedge clk) disable iff (reset) !(push && delete))
        else $error("push and delete in the same cycle");

endmodule

//--- verilog/buffer_arbiter.sv
/* shares the buffer read port between player and scanner
   player has fixed priority, grant and data are combinational */
`timescale 1ns/1ps
`include "morse_defines.svh"

module buffer_arbiter import morse_pkg::*; (
    buffer_read_if.arbiter           player,
    buffer_read_if.arbiter           scanner,
    output logic [`MORSE_SLOT_W-1:0] read_slot,
    input  char_code_t               read_data
);

    assign player.grant  = player.req;
    assign scanner.grant = scanner.req && !player.req; // scanner waits

    assign read_slot = player.req ? player.slot : scanner.slot;

    assign player.data  = read_data;
    assign scanner.data = read_data;

    always_comb begin
        a_one_grant : assert (!(player.grant && scanner.grant))
            else $error("both clients granted");
    end

endmodule

//--- verilog/beep_player.sv
/* plays one buffer slot, or every non-blank slot oldest first,
   as Morse beeps; busy is high from the cycle after play until done */
`timescale 1ns/1ps
`include "morse_defines.svh"

module beep_player import morse_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     play,
    input  logic                     play_all,
    input  logic [`MORSE_SLOT_W-1:0] play_slot,
    buffer_read_if.client            rd,
    output logic                     beep,
    output logic                     busy
);

    localparam int UNIT   = `MORSE_DOT_TICKS;
    localparam int TICK_W = $clog2(3 * UNIT);

    typedef enum logic [2:0] {IDLE, FETCH, CGAP, MARK, GAP} state_t;

    state_t                    state;
    logic [TICK_W-1:0]         ticks;
    logic [`MORSE_MAX_LEN-1:0] elems;    // current element in the top bit
    logic [2:0]                left;     // elements still to sound
    logic [`MORSE_SLOT_W-1:0]  slot_idx;
    logic                      all_mode;
    logic                      started;  // a character already sounded
    morse_pattern_t            fetched;
    logic                      cur_dash;
    logic                      more_slots;

    function automatic logic [TICK_W-1:0] mark_ticks(input logic is_dash);
        return is_dash ? TICK_W'(3 * UNIT - 1) : TICK_W'(UNIT - 1);
    endfunction

    assign fetched    = char_to_pattern(rd.data);
    assign cur_dash   = elems[`MORSE_MAX_LEN-1];
    assign more_slots = all_mode && (slot_idx != '0);

    assign rd.req  = (state == FETCH);
    assign rd.slot = slot_idx;
    assign beep    = (state == MARK);
    assign busy    = (state != IDLE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            ticks    <= '0;
            elems    <= '0;
            left     <= '0;
            slot_idx <= '0;
            all_mode <= 1'b0;
            started  <= 1'b0;
        end else begin
            case (state)
                IDLE: if (play) begin
                    slot_idx <= play_all ? `MORSE_SLOT_W'(`MORSE_SLOTS - 1) : play_slot;
                    all_mode <= play_all;
                    started  <= 1'b0;
                    state    <= FETCH;
                end
                FETCH: if (rd.grant) begin
                    if (rd.data == BLANK) begin
                        if (more_slots)
                            slot_idx <= slot_idx - 1'b1; // skip blank
                        else
                            state <= IDLE;
                    end else begin
                        elems   <= fetched.elems;
                        left    <= fetched.len;
                        started <= 1'b1;
                        if (started) begin
                            // this fetch cycle counts toward the 3-unit gap
                            ticks <= TICK_W'(3 * UNIT - 2);
                            state <= CGAP;
                        end else begin
                            ticks <= mark_ticks(fetched.elems[`MORSE_MAX_LEN-1]);
                            state <= MARK;
                        end
                    end
                end
                MARK: if (ticks == '0) begin
                    if (left > 3'd1) begin
                        elems <= elems << 1;
                        left  <= left - 3'd1;
                        ticks <= TICK_W'(UNIT - 1);
                        state <= GAP;
                    end else if (more_slots) begin
                        slot_idx <= slot_idx - 1'b1;
                        state    <= FETCH;
                    end else begin
                        state <= IDLE;
                    end
                end else begin
                    ticks <= ticks - 1'b1;
                end
                CGAP, GAP: if (ticks == '0) begin
                    ticks <= mark_ticks(cur_dash);
                    state <= MARK;
                end else begin
                    ticks <= ticks - 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- verilog/seg_scanner.sv
/* scans the eight buffer slots onto the seven-segment display,
   holding each digit for a fixed number of granted cycles */
`timescale 1ns/1ps
`include "morse_defines.svh"

module seg_scanner import morse_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    buffer_read_if.client           rd,
    output logic [`MORSE_SLOTS-1:0] seg_en,
    output logic [7:0]              seg_out
);

    localparam int TICK_W = $clog2(`MORSE_SCAN_TICKS);

    logic [TICK_W-1:0]        ticks;
    logic [`MORSE_SLOT_W-1:0] digit;

    assign rd.req  = 1'b1; // refresh the glyph every cycle
    assign rd.slot = digit;

    // stalls whole while the player owns the read port
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ticks   <= '0;
            digit   <= '0;
            seg_en  <= '1;    // all digits off
            seg_out <= 8'hFF;
        end else if (rd.grant) begin
            seg_en  <= ~(`MORSE_SLOTS'(1) << digit);
            seg_out <= char_to_glyph(rd.data);
            if (ticks == TICK_W'(`MORSE_SCAN_TICKS - 1)) begin
                ticks <= '0;
                if (digit == `MORSE_SLOT_W'(`MORSE_SLOTS - 1))
                    digit <= '0;
                else
                    digit <= digit + 1'b1;
            end else begin
                ticks <= ticks + 1'b1;
            end
        end
    end

endmodule

//--- verilog/morse_top.sv
/* Morse terminal top level: decoder and buffer, plus the beep player
   and display scanner sharing the buffer read port through the arbiter */
`timescale 1ns/1ps
`include "morse_defines.svh"

module morse_top import morse_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dot,
    input  logic                      dash,
    input  logic                      commit,
    input  logic                      backspace,
    input  logic                      play,
    input  logic                      play_all,
    input  logic [`MORSE_SLOT_W-1:0]  play_slot,
    output logic [`MORSE_MAX_LEN-1:0] pattern_leds,
    output logic [`MORSE_MAX_LEN-1:0] length_leds,
    output logic                      error,
    output logic                      beep,
    output logic                      busy,
    output logic [`MORSE_SLOTS-1:0]   seg_en,
    output logic [7:0]                seg_out
);

    logic                     push;
    logic                     delete;
    char_code_t               push_char;
    logic [`MORSE_SLOT_W-1:0] read_slot;
    char_code_t               read_data;

    buffer_read_if player_rd ();
    buffer_read_if scanner_rd ();

    morse_decoder decoder_i (
        .clk, .reset, .dot, .dash, .commit, .backspace,
        .pattern_leds, .length_leds, .error,
        .push, .delete, .push_char
    );

    char_buffer buffer_i (
        .clk, .reset, .push, .delete, .push_char,
        .read_slot, .read_data
    );

    buffer_arbiter arbiter_i (
        .player    (player_rd.arbiter),
        .scanner   (scanner_rd.arbiter),
        .read_slot,
        .read_data
    );

    beep_player player_i (
        .clk, .reset, .play, .play_all, .play_slot,
        .rd   (player_rd.client),
        .beep,
        .busy
    );

    seg_scanner scanner_i (
        .clk, .reset,
        .rd      (scanner_rd.client),
        .seg_en,
        .seg_out
    );

endmodule

//--- testbench/morse_tb.sv
/* self-checking testbench for the Morse terminal; a table of patterns is keyed in,
   committed and then checked against a slot model on the display and in playback */
`timescale 1ns/1ps
`include "morse_defines.svh"

module morse_tb import morse_pkg::*; ();

    localparam int UNIT        = `MORSE_DOT_TICKS;
    localparam int LAST        = `MORSE_MAX_LEN - 1;
    localparam int NUM_ENTRIES = 13;
    localparam int MAX_PLAY    = `MORSE_SLOTS * 24 * UNIT; // eight five-dash characters
    localparam int SCAN_ROUND  = `MORSE_SLOTS * `MORSE_SCAN_TICKS;
    localparam int WATCHDOG    = (NUM_ENTRIES + 8) * (MAX_PLAY + 3 * SCAN_ROUND);

    typedef struct packed {
        logic [2:0]                len;
        logic [`MORSE_MAX_LEN-1:0] elems; // first element on top, dash = 1
        logic                      bad;   // commit must raise error
        char_code_t                code;
        logic [7:0]                glyph; // active low, dp off
    } entry_t;

    localparam entry_t STIM [NUM_ENTRIES] = '{
        '{3'd1, 5'b00000, 1'b0, E,     8'h86},
        '{3'd1, 5'b10000, 1'b0, T,     8'h87},
        '{3'd2, 5'b01000, 1'b0, A,     8'h88},
        '{3'd4, 5'b11110, 1'b1, BLANK, 8'hFF}, // four dashes, no letter
        '{3'd2, 5'b10000, 1'b0, N,     8'hAB},
        '{3'd3, 5'b00000, 1'b0, S,     8'h92},
        '{3'd0, 5'b00000, 1'b1, BLANK, 8'hFF}, // empty commit
        '{3'd3, 5'b11100, 1'b0, O,     8'hA3},
        '{3'd3, 5'b10100, 1'b0, K,     8'h8A},
        '{3'd5, 5'b00000, 1'b0, DIG_5, 8'h92},
        '{3'd5, 5'b01010, 1'b1, BLANK, 8'hFF},
        '{3'd4, 5'b11010, 1'b0, Q,     8'h98},
        '{3'd5, 5'b11111, 1'b0, DIG_0, 8'hC0}
    };

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      dot, dash, commit, backspace;
    logic                      play, play_all;
    logic [`MORSE_SLOT_W-1:0]  play_slot;
    logic [`MORSE_MAX_LEN-1:0] pattern_leds, length_leds;
    logic                      error, beep, busy;
    logic [`MORSE_SLOTS-1:0]   seg_en;
    logic [7:0]                seg_out;

    int                        model [`MORSE_SLOTS]; // table index per slot, -1 blank
    logic [`MORSE_MAX_LEN-1:0] exp_pat;
    int                        exp_len;
    int                        checks = 0;
    int                        errors = 0;

    morse_top morse_top_i (.*);

    always #2 clk = ~clk;

    initial begin
        #(WATCHDOG * 4);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_value(input int actual, input int expected, input string what);
        checks++;
        assert (actual == expected)
        else begin
            errors++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [`MORSE_MAX_LEN-1:0] thermometer(input int n);
        logic [`MORSE_MAX_LEN-1:0] t;
        t = '0;
        for (int i = 0; i < n; i++)
            t[LAST-i] = 1'b1;
        return t;
    endfunction

    task automatic check_leds(input string step);
        check_value(pattern_leds, exp_pat, {step, ": pattern_leds"});
        check_value(length_leds, thermometer(exp_len), {step, ": length_leds"});
    endtask

    task automatic strobe_element(input logic is_dash);
        @(negedge clk);
        dot  = !is_dash;
        dash = is_dash;
        @(negedge clk);
        dot  = 1'b0;
        dash = 1'b0;
        if (exp_len < `MORSE_MAX_LEN) begin // full pattern ignores it
            exp_pat[LAST-exp_len] = is_dash;
            exp_len++;
        end
        check_leds("element");
        check_value(error, 0, "error after element");
    endtask

    task automatic pulse_backspace();
        @(negedge clk);
        backspace = 1'b1;
        @(negedge clk);
        backspace = 1'b0;
        if (exp_len > 0) begin
            exp_len--;
            exp_pat[LAST-exp_len] = 1'b0;
        end else begin
            for (int s = 0; s < `MORSE_SLOTS - 1; s++)
                model[s] = model[s+1];
            model[`MORSE_SLOTS-1] = -1;
        end
        check_leds("backspace");
    endtask

    task automatic commit_entry(input int n);
        @(negedge clk);
        commit = 1'b1;
        @(negedge clk);
        commit  = 1'b0;
        exp_pat = '0;
        exp_len = 0;
        check_leds("commit");
        check_value(error, STIM[n].bad, $sformatf("error after commit of %s", STIM[n].code.name()));
        if (!STIM[n].bad) begin
            for (int s = `MORSE_SLOTS - 1; s > 0; s--)
                model[s] = model[s-1];
            model[0] = n;
        end
    endtask

    task automatic check_display();
        int         held;
        int         waited;
        logic [7:0] want;
        for (int d = 0; d < `MORSE_SLOTS; d++) begin
            held   = 0;
            waited = 0;
            while (held < 3 && waited < 2 * SCAN_ROUND) begin
                @(negedge clk);
                waited++;
                held = (seg_en == ~(8'd1 << d)) ? held + 1 : 0;
            end
            want = (model[d] < 0) ? 8'hFF : STIM[model[d]].glyph;
            if (held < 3) begin
                errors++;
                $display("digit %0d was never held on the display", d);
            end else begin
                check_value(seg_out, want, $sformatf("glyph of digit %0d", d));
            end
        end
    endtask

    task automatic play_and_check(input logic all, input int slot, input logic extra);
        int     exp_marks[$];
        int     exp_gaps[$];
        int     marks[$];
        int     gaps[$];
        int     run;
        int     cycles;
        int     chars;
        int     exp_chars;
        logic   level;
        logic   seen;
        entry_t e;
        run       = 0;
        cycles    = 0;
        exp_chars = 0;
        level     = 1'b0;
        seen      = 1'b0;
        for (int s = `MORSE_SLOTS - 1; s >= 0; s--) begin
            if ((all || s == slot) && model[s] >= 0) begin
                e = STIM[model[s]];
                if (exp_chars > 0)
                    exp_gaps.push_back(3 * UNIT); // between characters
                for (int k = 0; k < e.len; k++) begin
                    if (k > 0)
                        exp_gaps.push_back(UNIT);
                    exp_marks.push_back(e.elems[LAST-k] ? 3 * UNIT : UNIT);
                end
                exp_chars++;
            end
        end
        @(negedge clk);
        play      = 1'b1;
        play_all  = all;
        play_slot = 3'(slot);
        @(negedge clk);
        play = 1'b0;
        check_value(busy, 1, "busy after play");
        while (busy && cycles < MAX_PLAY) begin
            if (beep !== level) begin
                if (level)
                    marks.push_back(run);
                else if (seen)
                    gaps.push_back(run);
                seen  = seen || beep;
                level = beep;
                run   = 0;
            end
            run++;
            play = extra && (cycles % 10 == 5); // must be ignored while busy
            @(negedge clk);
            cycles++;
        end
        play = 1'b0;
        if (level)
            marks.push_back(run);
        if (busy) begin
            errors++;
            $display("playback did not finish, busy still high");
        end
        chars = (marks.size() > 0) ? 1 : 0;
        foreach (gaps[k])
            if (gaps[k] >= 3 * UNIT)
                chars++;
        check_value(chars, exp_chars, "characters sounded");
        check_value(marks.size(), exp_marks.size(), "number of marks");
        check_value(gaps.size(), exp_gaps.size(), "number of gaps");
        for (int k = 0; k < marks.size() && k < exp_marks.size(); k++)
            check_value(marks[k], exp_marks[k], $sformatf("width of mark %0d", k));
        for (int k = 0; k < gaps.size() && k < exp_gaps.size(); k++)
            check_value(gaps[k], exp_gaps[k], $sformatf("width of gap %0d", k));
        repeat (3) begin
            @(negedge clk);
            check_value(busy, 0, "busy after playback");
        end
    endtask

    task automatic play_random_slot();
        int filled[$];
        foreach (model[s])
            if (model[s] >= 0)
                filled.push_back(s);
        if (filled.size() > 0)
            play_and_check(1'b0, filled[$urandom % filled.size()], 1'b0);
    endtask

    initial begin
        int seed_ret;
        seed_ret  = $urandom(32'he857de57);
        reset     = 1'b1;
        dot       = 1'b0;
        dash      = 1'b0;
        commit    = 1'b0;
        backspace = 1'b0;
        play      = 1'b0;
        play_all  = 1'b0;
        play_slot = '0;
        exp_pat   = '0;
        exp_len   = 0;
        foreach (model[s])
            model[s] = -1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value(seg_en, 8'hFF, "seg_en in reset");
        check_value({beep, busy, error}, 0, "beep, busy, error in reset");
        check_leds("reset");
        reset = 1'b0;

        for (int n = 0; n < NUM_ENTRIES; n++) begin
            for (int k = 0; k < STIM[n].len; k++)
                strobe_element(STIM[n].elems[LAST-k]);
            if (STIM[n].len == `MORSE_MAX_LEN)
                strobe_element(1'b1); // sixth element
            if (STIM[n].len >= 2) begin
                pulse_backspace();
                strobe_element(STIM[n].elems[`MORSE_MAX_LEN - STIM[n].len]);
            end
            commit_entry(n);
            check_display();
            if (n % 4 == 3)
                play_random_slot();
        end

        // empty pattern, so these delete the newest characters
        repeat (2) begin
            pulse_backspace();
            check_display();
        end
        play_and_check(1'b0, `MORSE_SLOTS - 1, 1'b0); // blank top slot
        play_and_check(1'b1, 0, 1'b1);
        play_random_slot();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- morse.f
+incdir+verilog
verilog/morse_pkg.sv
verilog/buffer_read_if.sv
verilog/morse_decoder.sv
verilog/char_buffer.sv
verilog/buffer_arbiter.sv
verilog/beep_player.sv
verilog/seg_scanner.sv
verilog/morse_top.sv
testbench/morse_tb.sv

//--- run.sh
#!/bin/sh
# build the Morse terminal testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f morse.f --top-module morse_tb -o morse_sim || exit 1
out=$(./obj_dir/morse_sim)
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1
